// ==== project.f ====
+incdir+source
source/organ_pkg.sv
source/sample_if.sv
source/tone_generator.sv
source/sample_fifo.sv
source/dac_serializer.sv
source/organ_top.sv
tb/organ_tb.sv

// ==== Bender.yml ====
package:
  name: organ

sources:
  - include_dirs:
      - source
    files:
      - source/organ_pkg.sv
      - source/sample_if.sv
      - source/tone_generator.sv
      - source/sample_fifo.sv
      - source/dac_serializer.sv
      - source/organ_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/organ_tb.sv

// ==== tb/organ_tb.sv ====
`timescale 1ns/1ps
`include "organ_params.svh"

module organ_tb;

  localparam int bclk_div       = 2;
  localparam int frame_cycles   = 64 * bclk_div;
  localparam int timeout_cycles = 4_000_000;

  logic        CLK_50M = 1'b0;
  logic        reset;
  logic [2:0]  note_sel;
  logic        enable;
  logic        dac_bclk;
  logic        dac_lrck;
  logic        dac_data;
  logic        underrun;

  int          error_count = 0;
  int          cycle_count = 0;
  logic [31:0] rng_state   = 32'h032f_8023;
  bit          frame_sync  = 1'b0;
  bit          run_pending = 1'b0;
  logic [7:0]  run_level;

  organ_top #(
    .bclk_div   (bclk_div),
    .fifo_depth (8)
  ) organ_top_i (
    .CLK_50M  (CLK_50M),
    .reset    (reset),
    .note_sel (note_sel),
    .enable   (enable),
    .dac_bclk (dac_bclk),
    .dac_lrck (dac_lrck),
    .dac_data (dac_data),
    .underrun (underrun)
  );

  always #10 CLK_50M = ~CLK_50M;

  always @(posedge CLK_50M)
  begin
    cycle_count++;
    if (cycle_count >= timeout_cycles)
    begin
      $display("Run timed out after %0d clock cycles", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  // ==========================================================================
  // Reference model and helpers
  // ==========================================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Half a note period in system cycles, from the note frequency
  function automatic int half_period_cycles(input int note);
    int freq_hz;
    case (note)
      0:       freq_hz = 523;
      1:       freq_hz = 587;
      2:       freq_hz = 659;
      3:       freq_hz = 698;
      4:       freq_hz = 783;
      5:       freq_hz = 880;
      6:       freq_hz = 987;
      default: freq_hz = 1046;
    endcase
    return `ORGAN_CLK_HZ / (2 * freq_hz);
  endfunction

  // One sample per frame, so a wave half spans floor or ceiling frames
  function automatic int run_min(input int note);
    return half_period_cycles(note) / frame_cycles;
  endfunction

  function automatic int run_max(input int note);
    return (half_period_cycles(note) + frame_cycles - 1) / frame_cycles;
  endfunction

  task automatic report_error(input string msg);
    error_count++;
    $display("ERROR %0t: %s", $time, msg);
  endtask

  task automatic check_quiet(input string phase);
    assert ({dac_bclk, dac_lrck, dac_data, underrun} === 4'b0000)
      else report_error($sformatf("link outputs not low %s", phase));
  endtask

  task automatic set_controls(input logic [2:0] note, input logic en);
    @(posedge CLK_50M);
    note_sel <= note;
    enable   <= en;
    frame_sync  = 1'b0;
    run_pending = 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge CLK_50M);
    reset <= 1'b1;
    repeat (9)
    begin
      @(posedge CLK_50M);
      @(negedge CLK_50M);
      check_quiet("during reset");
    end
    @(posedge CLK_50M);
    reset <= 1'b0;
    frame_sync  = 1'b0;
    run_pending = 1'b0;
  endtask

  // ==========================================================================
  // Frame decoder
  // ==========================================================================

  task automatic read_frame(output logic [15:0] left, output logic [15:0] right);
    logic [31:0] bits;
    int          n;
    if (!frame_sync)
    begin
      // Left slot starts where lrck falls
      @(posedge dac_bclk);
      while (dac_lrck !== 1'b1)
        @(posedge dac_bclk);
      while (dac_lrck !== 1'b0)
        @(posedge dac_bclk);
      frame_sync = 1'b1;
    end
    else
      @(posedge dac_bclk);
    for (n = 31; n >= 0; n--)
    begin
      if (n != 31)
        @(posedge dac_bclk);
      bits[n] = dac_data;
      assert (dac_lrck === (n < 16))
        else report_error($sformatf("lrck %b at frame bit %0d", dac_lrck, n));
    end
    left  = bits[31:16];
    right = bits[15:0];
  endtask

  task automatic check_format(input logic [15:0] left, input logic [15:0] right);
    assert (left[15:8] == `ORGAN_SAMPLE_HIGH || left[15:8] == `ORGAN_SAMPLE_LOW)
      else report_error($sformatf("sample byte %h is not a wave level", left[15:8]));
    assert (left[7:0] == `ORGAN_PAD_BYTE)
      else report_error($sformatf("pad byte %h, expected 01", left[7:0]));
    assert (left == right)
      else report_error($sformatf("left slot %h differs from right slot %h", left, right));
  endtask

  // Frames until the sample level changes
  task automatic next_run(output int len);
    logic [15:0] left;
    logic [15:0] right;
    bit          done;
    if (!run_pending)
    begin
      read_frame(left, right);
      check_format(left, right);
      run_level = left[15:8];
    end
    len  = 1;
    done = 1'b0;
    while (!done)
    begin
      read_frame(left, right);
      check_format(left, right);
      if (left[15:8] == run_level)
        len++;
      else
      begin
        run_level   = left[15:8];
        run_pending = 1'b1;
        done        = 1'b1;
      end
    end
  endtask

  // ==========================================================================
  // Directed tests
  // ==========================================================================

  task automatic test_reset_quiet();
    apply_reset();
    repeat (frame_cycles)
    begin
      @(negedge CLK_50M);
      check_quiet("before first frame");
    end
  endtask

  task automatic test_frame_format();
    logic [15:0] left;
    logic [15:0] right;
    int          i;
    set_controls(3'd0, 1'b1);
    for (i = 0; i < 20; i++)
    begin
      read_frame(left, right);
      // Stream fills during the first frames
      if (i >= 2)
        check_format(left, right);
    end
  endtask

  task automatic test_pitch(input int note);
    int len;
    int i;
    set_controls(3'(note), 1'b1);
    // Partial run, then one that may still hold the old pitch
    next_run(len);
    next_run(len);
    for (i = 0; i < 6; i++)
    begin
      next_run(len);
      assert (len == run_min(note) || len == run_max(note))
        else report_error($sformatf("note %0d run of %0d frames, expected %0d or %0d",
                                    note, len, run_min(note), run_max(note)));
    end
  endtask

  task automatic test_note_change();
    int old_note;
    int new_note;
    int limit;
    int len;
    int i;
    int k;
    old_note = 7;
    for (k = 0; k < 3; k++)
    begin
      new_note = old_note;
      while (new_note == old_note)
      begin
        rng_state = xorshift32(rng_state);
        new_note  = rng_state % 8;
      end
      limit = (run_max(old_note) > run_max(new_note)) ? run_max(old_note) : run_max(new_note);
      set_controls(3'(new_note), 1'b1);
      for (i = 1; i <= 5; i++)
      begin
        next_run(len);
        assert (len <= limit)
          else report_error($sformatf("run of %0d frames after change to note %0d",
                                      len, new_note));
        if (i >= 3)
          assert (len == run_min(new_note) || len == run_max(new_note))
            else report_error($sformatf("note %0d run of %0d frames after change",
                                        new_note, len));
      end
      old_note = new_note;
    end
  endtask

  task automatic test_underrun();
    logic [15:0] left;
    logic [15:0] right;
    int          i;
    set_controls(note_sel, 1'b0);
    read_frame(left, right);
    i = 0;
    while ({left, right} != 32'd0 && i < 4)
    begin
      read_frame(left, right);
      i++;
    end
    assert ({left, right} == 32'd0)
      else report_error("FIFO never drained after enable went low");
    for (i = 0; i < 4; i++)
    begin
      read_frame(left, right);
      assert ({left, right} == 32'd0)
        else report_error($sformatf("idle frame %h %h, expected zero", left, right));
    end
    assert (underrun === 1'b1)
      else report_error("underrun flag not set after FIFO ran dry");
    set_controls(note_sel, 1'b1);
    for (i = 0; i < 8; i++)
    begin
      read_frame(left, right);
      if (i >= 3)
        check_format(left, right);
      assert (underrun === 1'b1)
        else report_error("underrun flag cleared without a reset");
    end
    // Only a reset clears the flag
    test_reset_quiet();
  endtask

  initial
  begin
    int note;
    reset    = 1'b1;
    note_sel = 3'd0;
    enable   = 1'b0;
    test_reset_quiet();
    test_frame_format();
    for (note = 0; note < 8; note++)
      test_pitch(note);
    test_note_change();
    test_underrun();
    $display("Errors: %0d", error_count);
    if (error_count == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// ==== source/organ_top.sv ====
`timescale 1ns/1ps
`include "organ_params.svh"

module organ_top #(
  parameter int bclk_div   = `ORGAN_BCLK_DIV,
  parameter int fifo_depth = `ORGAN_FIFO_DEPTH
) (
  input  logic       CLK_50M,
  input  logic       reset,
  input  logic [2:0] note_sel,
  input  logic       enable,
  output logic       dac_bclk,
  output logic       dac_lrck,
  output logic       dac_data,
  output logic       underrun
);

  // One sample per frame of 32 bit clock periods
  localparam int sample_div = 64 * bclk_div;

  // ==========================================================================
  // Sample streams
  // ==========================================================================

  sample_if gen_to_fifo (
    .CLK_50M (CLK_50M),
    .reset   (reset)
  );

  sample_if fifo_to_dac (
    .CLK_50M (CLK_50M),
    .reset   (reset)
  );

  // ==========================================================================
  // Generator, buffer and DAC link
  // ==========================================================================

  tone_generator #(
    .sample_div (sample_div)
  ) tone_generator_i (
    .CLK_50M  (CLK_50M),
    .reset    (reset),
    .note_sel (note_sel),
    .enable   (enable),
    .samples  (gen_to_fifo)
  );

  sample_fifo #(
    .depth (fifo_depth)
  ) sample_fifo_i (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .wr      (gen_to_fifo),
    .rd      (fifo_to_dac)
  );

  dac_serializer #(
    .bclk_div (bclk_div)
  ) dac_serializer_i (
    .CLK_50M  (CLK_50M),
    .reset    (reset),
    .samples  (fifo_to_dac),
    .dac_bclk (dac_bclk),
    .dac_lrck (dac_lrck),
    .dac_data (dac_data),
    .underrun (underrun)
  );

endmodule

// ==== source/dac_serializer.sv ====
`timescale 1ns/1ps
`include "organ_params.svh"

module dac_serializer #(
  parameter int bclk_div = `ORGAN_BCLK_DIV
) (
  input  logic       CLK_50M,
  input  logic       reset,
  sample_if.consumer samples,
  output logic       dac_bclk,
  output logic       dac_lrck,
  output logic       dac_data,
  output logic       underrun
);

  localparam int div_w = (bclk_div > 1) ? $clog2(bclk_div) : 1;

  logic [div_w-1:0] div_cnt;
  logic             half_end;
  logic             bclk_int;
  logic [4:0]       bit_idx;
  logic [4:0]       next_idx;
  logic             frame_start;
  logic             started;
  logic [31:0]      frame_word;
  logic [31:0]      shift_reg;

  // ==========================================================================
  // Bit clock timing
  // ==========================================================================

  assign half_end    = (div_cnt == div_w'(bclk_div - 1));
  assign next_idx    = bit_idx + 5'd1;
  // Falling edge that closes bit 31
  assign frame_start = half_end && bclk_int && (bit_idx == 5'd31);

  always_ff @(posedge CLK_50M)
  begin
    if (reset || half_end)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // One sample per frame, taken only at the frame boundary
  assign samples.ready = frame_start;

  // Left slot then right slot, both carry the same sample
  assign frame_word = samples.valid ?
                      {samples.data, `ORGAN_PAD_BYTE, samples.data, `ORGAN_PAD_BYTE} :
                      32'd0;

  // ==========================================================================
  // Link outputs
  // ==========================================================================

  // Outputs stay low through the first frame time after reset
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      bclk_int <= 1'b0;
      bit_idx  <= '0;
      started  <= 1'b0;
      dac_bclk <= 1'b0;
      dac_lrck <= 1'b0;
      dac_data <= 1'b0;
      underrun <= 1'b0;
    end
    else if (half_end)
    begin
      bclk_int <= ~bclk_int;
      dac_bclk <= ~bclk_int && started;
      if (bclk_int)
      begin
        // Data and lrck move on the falling edge
        bit_idx  <= next_idx;
        dac_lrck <= started && next_idx[4];
        if (frame_start)
        begin
          started  <= 1'b1;
          dac_data <= frame_word[31];
          if (!samples.valid)
            underrun <= 1'b1;
        end
        else
        begin
          dac_data <= started && shift_reg[31];
        end
      end
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (half_end && bclk_int)
    begin
      if (frame_start)
        shift_reg <= {frame_word[30:0], 1'b0};
      else
        shift_reg <= {shift_reg[30:0], 1'b0};
    end
  end

endmodule

// ==== source/sample_fifo.sv ====
`timescale 1ns/1ps
`include "organ_params.svh"

module sample_fifo #(
  parameter int depth = `ORGAN_FIFO_DEPTH
) (
  input  logic       CLK_50M,
  input  logic       reset,
  sample_if.consumer wr,
  sample_if.producer rd
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  organ_pkg::sample_t mem [depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [cnt_w-1:0]   count;
  logic               push;
  logic               pop;

  // Full and empty come straight from the occupancy count
  assign wr.ready = (count != cnt_w'(depth));
  assign rd.valid = (count != '0);
  assign rd.data  = mem[rd_ptr];

  assign push = wr.valid && wr.ready;
  assign pop  = rd.valid && rd.ready;

  always_ff @(posedge CLK_50M)
  begin
    if (push)
      mem[wr_ptr] <= wr.data;
  end

  // Pointers wrap at depth so any depth works
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;

      // Push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== source/tone_generator.sv ====
`timescale 1ns/1ps
`include "organ_params.svh"

module tone_generator #(
  parameter int sample_div = 64 * `ORGAN_BCLK_DIV
) (
  input  logic              CLK_50M,
  input  logic              reset,
  input  logic [2:0]        note_sel,
  input  logic              enable,
  sample_if.producer        samples
);

  localparam int cnt_w = (sample_div > 1) ? $clog2(sample_div) : 1;

  logic [2:0]              note_meta;
  organ_pkg::note_e        note_sync;
  organ_pkg::half_period_t half_cnt;
  organ_pkg::half_period_t half_reload;
  logic                    wave;
  logic [cnt_w-1:0]        sample_cnt;
  logic                    strobe;
  logic                    load_sample;

  // ==========================================================================
  // Note select synchronizer and square wave
  // ==========================================================================

  // Switches may move at any time
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      note_meta <= '0;
      note_sync <= organ_pkg::note_do;
    end
    else
    begin
      note_meta <= note_sel;
      note_sync <= organ_pkg::note_e'(note_meta);
    end
  end

  // Counter runs from half period minus one down to zero
  assign half_reload = organ_pkg::note_half_period(note_sync) - 32'd1;

  // New note is picked up only at a wave toggle
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      half_cnt <= '0;
      wave     <= 1'b0;
    end
    else if (half_cnt == '0)
    begin
      half_cnt <= half_reload;
      wave     <= ~wave;
    end
    else
    begin
      half_cnt <= half_cnt - 32'd1;
    end
  end

  // ==========================================================================
  // Sample rate strobe and stream output
  // ==========================================================================

  assign strobe = enable && (sample_cnt == cnt_w'(sample_div - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset || !enable || strobe)
      sample_cnt <= '0;
    else
      sample_cnt <= sample_cnt + 1'b1;
  end

  // Strobe is dropped while an earlier sample still waits
  assign load_sample = strobe && (!samples.valid || samples.ready);

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      samples.valid <= 1'b0;
    else if (load_sample)
      samples.valid <= 1'b1;
    else if (samples.ready)
      samples.valid <= 1'b0;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (load_sample)
      samples.data <= wave ? `ORGAN_SAMPLE_HIGH : `ORGAN_SAMPLE_LOW;
  end

endmodule

// ==== source/sample_if.sv ====
`timescale 1ns/1ps

// Sample stream with valid/ready handshake
// A transfer happens on a rising edge with valid and ready both high
interface sample_if (
  input logic CLK_50M,
  input logic reset
);

  logic              valid;
  logic              ready;
  organ_pkg::sample_t data;

  modport producer (
    input  CLK_50M,
    input  reset,
    input  ready,
    output valid,
    output data
  );

  modport consumer (
    input  CLK_50M,
    input  reset,
    input  valid,
    input  data,
    output ready
  );

endinterface

// ==== source/organ_pkg.sv ====
`include "organ_params.svh"

package organ_pkg;

  // Switch order, 0 is the low do and 7 the high Do
  typedef enum logic [2:0] {
    note_do,
    note_re,
    note_mi,
    note_fa,
    note_so,
    note_la,
    note_si,
    note_do_hi
  } note_e;

  typedef logic signed [7:0] sample_t;

  // System cycles in half a note period
  typedef logic [31:0] half_period_t;

  // Clock rate over twice the note frequency, truncated
  function automatic half_period_t note_half_period(note_e note);
    logic [31:0] freq_hz;
    case (note)
      note_do:    freq_hz = 32'd523;
      note_re:    freq_hz = 32'd587;
      note_mi:    freq_hz = 32'd659;
      note_fa:    freq_hz = 32'd698;
      note_so:    freq_hz = 32'd783;
      note_la:    freq_hz = 32'd880;
      note_si:    freq_hz = 32'd987;
      note_do_hi: freq_hz = 32'd1046;
      default:    freq_hz = 32'd523;
    endcase
    return `ORGAN_CLK_HZ / (32'd2 * freq_hz);
  endfunction

endpackage

// ==== source/organ_params.svh ====
`ifndef ORGAN_PARAMS_SVH
`define ORGAN_PARAMS_SVH

// ==========================================================================
// Organ build constants
// ==========================================================================

// System clock rate in Hz
`define ORGAN_CLK_HZ 32'd50_000_000

// System cycles per half period of the DAC bit clock
`define ORGAN_BCLK_DIV 2

// Sample FIFO entries
`define ORGAN_FIFO_DEPTH 8

// Signed sample codes for the two square wave levels
`define ORGAN_SAMPLE_HIGH 8'h7F
`define ORGAN_SAMPLE_LOW 8'h80

// Low byte of every 16-bit channel slot
`define ORGAN_PAD_BYTE 8'h01

`endif
